/* axi_wr_pkg.sv */
package axi_wr_pkg;

	// bus and line geometry
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int LINE_W     = 512;
	localparam int LINE_BEATS = LINE_W / DATA_W;
	localparam int BEAT_CNT_W = 4;
	localparam int STRB_W     = DATA_W / 8;

	// request type doubles as awsize
	localparam int SIZE_W = 3;

	// burst length codes
	localparam int LEN_W = 4;
	localparam logic [LEN_W-1:0] LEN_LINE   = 4'd15;
	localparam logic [LEN_W-1:0] LEN_SINGLE = 4'd0;

	// burst type codes
	localparam int BURST_W = 2;
	localparam logic [BURST_W-1:0] BURST_INCR  = 2'b01;
	localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;

	// all writes carry the same transaction id
	localparam int ID_W = 4;
	localparam logic [ID_W-1:0] WR_ID = 4'd1;

endpackage

/* wr_req_capture.sv */
`timescale 1ns/1ps

module wr_req_capture (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             wr_req,
	input  logic [axi_wr_pkg::ADDR_W-1:0]    wr_addr,
	input  logic [axi_wr_pkg::SIZE_W-1:0]    wr_type,
	input  logic [axi_wr_pkg::STRB_W-1:0]    wr_wstrb,
	input  logic                             uncached,
	input  logic                             awready,
	input  logic                             done,
	output logic                             wr_rdy,
	output logic                             accept,
	output logic                             uncached_q,
	output logic [axi_wr_pkg::ADDR_W-1:0]    awaddr,
	output logic [axi_wr_pkg::SIZE_W-1:0]    awsize,
	output logic [axi_wr_pkg::LEN_W-1:0]     awlen,
	output logic [axi_wr_pkg::BURST_W-1:0]   awburst,
	output logic [axi_wr_pkg::STRB_W-1:0]    wstrb
);

	logic                           busy;
	logic [axi_wr_pkg::ADDR_W-1:0]  addr_q;
	logic [axi_wr_pkg::SIZE_W-1:0]  type_q;
	logic [axi_wr_pkg::STRB_W-1:0]  strb_q;

	// one write in flight, and only when the slave can take an address
	assign wr_rdy = !busy && awready;
	assign accept = wr_req && wr_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	// request fields held for the whole transaction
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q     <= wr_addr;
			type_q     <= wr_type;
			strb_q     <= wr_wstrb;
			uncached_q <= uncached;
		end
	end

	assign awaddr = addr_q;
	assign awsize = type_q;
	assign wstrb  = strb_q;

	// uncached word is a single fixed beat, a line is a full incrementing burst
	assign awlen   = uncached_q ? axi_wr_pkg::LEN_SINGLE : axi_wr_pkg::LEN_LINE;
	assign awburst = uncached_q ? axi_wr_pkg::BURST_FIXED : axi_wr_pkg::BURST_INCR;

	// the cache must wait for wr_rdy before issuing the next request
	a_no_req_while_busy: assert property (
		@(posedge clk) disable iff (!rst)
		wr_req |-> !busy
	) else $error("error at %0t: wr_req while a write is in flight", $time);

endmodule

/* wr_line_buffer.sv */
`timescale 1ns/1ps

module wr_line_buffer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           accept,
	input  logic                           uncached,
	input  logic [axi_wr_pkg::LINE_W-1:0]  wr_line,
	input  logic [axi_wr_pkg::DATA_W-1:0]  wr_word,
	input  logic                           beat,
	output logic [axi_wr_pkg::DATA_W-1:0]  wdata
);

	logic [axi_wr_pkg::LINE_W-1:0] line_q;
	logic [axi_wr_pkg::LINE_W-1:0] load_val;

	// uncached word sits in the lowest slot, upper words are never sent
	always_comb
	begin
		if (uncached)
			load_val = {{(axi_wr_pkg::LINE_W - axi_wr_pkg::DATA_W){1'b0}}, wr_word};
		else
			load_val = wr_line;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			line_q <= '0;
		else if (accept)
			line_q <= load_val;
		else if (beat)
			// drop the word just sent, lowest word goes out first
			line_q <= {{axi_wr_pkg::DATA_W{1'b0}},
				line_q[axi_wr_pkg::LINE_W-1:axi_wr_pkg::DATA_W]};
	end

	assign wdata = line_q[axi_wr_pkg::DATA_W-1:0];

endmodule

/* axi_wr_channel.sv */
`timescale 1ns/1ps

module axi_wr_channel (
	input  logic clk,
	input  logic rst,
	input  logic accept,
	input  logic uncached_q,
	input  logic awready,
	input  logic wready,
	input  logic bvalid,
	output logic awvalid,
	output logic wvalid,
	output logic wlast,
	output logic beat,
	output logic done
);

	// write phases
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ADDR = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_RESP = 2'd3;

	localparam logic [axi_wr_pkg::BEAT_CNT_W-1:0] LAST_BEAT =
		axi_wr_pkg::BEAT_CNT_W'(axi_wr_pkg::LINE_BEATS - 1);

	logic [1:0]                           state;
	logic [1:0]                           state_nxt;
	logic [axi_wr_pkg::BEAT_CNT_W-1:0]    beat_cnt;
	logic                                 last_beat;

	assign awvalid = (state == S_ADDR);
	assign wvalid  = (state == S_DATA);

	// uncached has only one beat, a line ends on its sixteenth
	assign last_beat = uncached_q || (beat_cnt == LAST_BEAT);
	assign wlast     = wvalid && last_beat;

	assign beat = wvalid && wready;
	// bready is tied high so bvalid alone finishes the response
	assign done = (state == S_RESP) && bvalid;

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
			begin
				if (accept)
					state_nxt = S_ADDR;
			end
			S_ADDR:
			begin
				if (awready)
					state_nxt = S_DATA;
			end
			S_DATA:
			begin
				if (beat && last_beat)
					state_nxt = S_RESP;
			end
			S_RESP:
			begin
				if (bvalid)
					state_nxt = S_IDLE;
			end
			default:
			begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	// beat counter holds while wready is low
	always_ff @(posedge clk)
	begin
		if (!rst)
			beat_cnt <= '0;
		else if (beat)
		begin
			if (last_beat)
				beat_cnt <= '0;
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// a new write only starts from idle
	a_accept_in_idle: assert property (
		@(posedge clk) disable iff (!rst)
		accept |-> state == S_IDLE
	) else $error("error at %0t: accept while a write is in progress", $time);

	// count is back at zero between bursts
	a_cnt_clear_outside_data: assert property (
		@(posedge clk) disable iff (!rst)
		!wvalid |-> beat_cnt == '0
	) else $error("error at %0t: beat count not cleared outside the data phase", $time);

endmodule

/* axi_wr_bridge.sv */
`timescale 1ns/1ps

module axi_wr_bridge (
	input  logic                             clk,
	input  logic                             rst,
	// cache side
	input  logic                             wr_req,
	input  logic [axi_wr_pkg::ADDR_W-1:0]    wr_addr,
	input  logic [axi_wr_pkg::SIZE_W-1:0]    wr_type,
	input  logic [axi_wr_pkg::STRB_W-1:0]    wr_wstrb,
	input  logic [axi_wr_pkg::LINE_W-1:0]    wr_line,
	input  logic [axi_wr_pkg::DATA_W-1:0]    wr_word,
	input  logic                             uncached,
	output logic                             wr_rdy,
	// write address channel
	output logic [axi_wr_pkg::ID_W-1:0]      awid,
	output logic [axi_wr_pkg::ADDR_W-1:0]    awaddr,
	output logic [axi_wr_pkg::LEN_W-1:0]     awlen,
	output logic [axi_wr_pkg::SIZE_W-1:0]    awsize,
	output logic [axi_wr_pkg::BURST_W-1:0]   awburst,
	output logic                             awvalid,
	input  logic                             awready,
	// write data channel
	output logic [axi_wr_pkg::ID_W-1:0]      wid,
	output logic [axi_wr_pkg::DATA_W-1:0]    wdata,
	output logic [axi_wr_pkg::STRB_W-1:0]    wstrb,
	output logic                             wlast,
	output logic                             wvalid,
	input  logic                             wready,
	// write response channel
	input  logic [axi_wr_pkg::ID_W-1:0]      bid,
	input  logic [1:0]                       bresp,
	input  logic                             bvalid,
	output logic                             bready
);

	logic accept;
	logic uncached_q;
	logic beat;
	logic done;

	// responses are always taken, every write uses one id
	assign awid   = axi_wr_pkg::WR_ID;
	assign wid    = axi_wr_pkg::WR_ID;
	assign bready = 1'b1;

	wr_req_capture u_wr_req_capture (
		.clk        (clk),
		.rst        (rst),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_type    (wr_type),
		.wr_wstrb   (wr_wstrb),
		.uncached   (uncached),
		.awready    (awready),
		.done       (done),
		.wr_rdy     (wr_rdy),
		.accept     (accept),
		.uncached_q (uncached_q),
		.awaddr     (awaddr),
		.awsize     (awsize),
		.awlen      (awlen),
		.awburst    (awburst),
		.wstrb      (wstrb)
	);

	// loads with the live kind, since uncached_q updates on the same edge
	wr_line_buffer u_wr_line_buffer (
		.clk      (clk),
		.rst      (rst),
		.accept   (accept),
		.uncached (uncached),
		.wr_line  (wr_line),
		.wr_word  (wr_word),
		.beat     (beat),
		.wdata    (wdata)
	);

	axi_wr_channel u_axi_wr_channel (
		.clk        (clk),
		.rst        (rst),
		.accept     (accept),
		.uncached_q (uncached_q),
		.awready    (awready),
		.wready     (wready),
		.bvalid     (bvalid),
		.awvalid    (awvalid),
		.wvalid     (wvalid),
		.wlast      (wlast),
		.beat       (beat),
		.done       (done)
	);

endmodule

/* tb_axi_wr_bridge.sv */
`timescale 1ns/1ps

module tb_axi_wr_bridge;

	localparam int NUM_REQS   = 20;
	localparam int MAX_CYCLES = NUM_REQS * 16 * 8;

	logic         clk;
	logic         rst;
	logic         wr_req;
	logic [31:0]  wr_addr;
	logic [2:0]   wr_type;
	logic [3:0]   wr_wstrb;
	logic [511:0] wr_line;
	logic [31:0]  wr_word;
	logic         uncached;
	logic         wr_rdy;
	logic [3:0]   awid;
	logic [31:0]  awaddr;
	logic [3:0]   awlen;
	logic [2:0]   awsize;
	logic [1:0]   awburst;
	logic         awvalid;
	logic         awready = 1'b1;
	logic [3:0]   wid;
	logic [31:0]  wdata;
	logic [3:0]   wstrb;
	logic         wlast;
	logic         wvalid;
	logic         wready = 1'b0;
	logic [3:0]   bid = 4'd1;
	logic [1:0]   bresp = 2'b00;
	logic         bvalid = 1'b0;
	logic         bready;

	// expected request held until the next one is issued
	logic [31:0]  exp_addr;
	logic [2:0]   exp_size;
	logic [3:0]   exp_strb;
	logic         exp_unc;
	logic [511:0] exp_line;
	logic [31:0]  exp_word;
	logic [4:0]   exp_beats;
	logic [31:0]  exp_wdata;

	logic [4:0]   beat_idx;
	logic         in_flight;
	logic         resp_owed;
	int           aw_cnt;
	int           b_cnt;
	int           cycles = 0;
	logic [31:0]  beat_log[$];

	axi_wr_bridge u_axi_wr_bridge (.*);

	function automatic string error_line(input string what);
		return $sformatf("error at %0t: %s", $time, what);
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// line words go out lowest first
	assign exp_beats = exp_unc ? 5'd1 : 5'd16;
	assign exp_wdata = exp_unc ? exp_word : exp_line[32*beat_idx +: 32];

	// AXI slave with random stalls
	always @(negedge clk)
	begin
		if (!rst)
		begin
			awready <= 1'b1;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end
		else
		begin
			if (awvalid)
				awready <= ($urandom_range(0, 3) != 0);
			else
				awready <= 1'b1;
			wready <= ($urandom_range(0, 3) != 0);
			// bvalid holds until taken since bready is always high
			if (!resp_owed)
				bvalid <= 1'b0;
			else if (!bvalid)
				bvalid <= ($urandom_range(0, 1) != 0);
		end
	end

	// bus monitor that records every data beat
	always @(posedge clk)
	begin
		if (!rst)
		begin
			beat_idx  <= '0;
			in_flight <= 1'b0;
			resp_owed <= 1'b0;
			aw_cnt    <= 0;
			b_cnt     <= 0;
		end
		else
		begin
			if (wr_req && wr_rdy)
				in_flight <= 1'b1;
			else if (bvalid && bready)
				in_flight <= 1'b0;
			if (awvalid && awready)
			begin
				aw_cnt   <= aw_cnt + 1;
				beat_idx <= '0;
			end
			else if (wvalid && wready)
			begin
				beat_idx <= beat_idx + 5'd1;
				beat_log.push_back(wdata);
			end
			if (wvalid && wready && wlast)
				resp_owed <= 1'b1;
			else if (bvalid && bready)
				resp_owed <= 1'b0;
			if (bvalid && bready)
				b_cnt <= b_cnt + 1;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("timeout: run not finished after %0d cycles", cycles));
	end

	a_reset_quiet: assert property (@(posedge clk)
		!rst |=> (!awvalid && !wvalid && !wlast))
		else abort_run(error_line("valid or wlast high during or right after reset"));

	a_ids_const: assert property (@(posedge clk) disable iff (!rst)
		awid == 4'd1 && wid == 4'd1 && bready)
		else abort_run(error_line("awid, wid or bready not at their fixed values"));

	a_aw_fields: assert property (@(posedge clk) disable iff (!rst)
		awvalid |-> (awaddr == exp_addr && awsize == exp_size
			&& awlen == (exp_unc ? 4'd0 : 4'd15)
			&& awburst == (exp_unc ? 2'b00 : 2'b01)))
		else abort_run(error_line("write address fields differ from the request"));

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen)
			&& $stable(awsize) && $stable(awburst))
		else abort_run(error_line("address channel changed while stalled"));

	a_w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
		else abort_run(error_line("data channel changed while stalled"));

	a_w_data: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> wdata == exp_wdata && wstrb == exp_strb)
		else abort_run(error_line("wrong wdata or wstrb on a data beat"));

	a_w_count: assert property (@(posedge clk) disable iff (!rst)
		wvalid |-> beat_idx < exp_beats)
		else abort_run(error_line("more data beats than the burst holds"));

	a_w_last: assert property (@(posedge clk) disable iff (!rst)
		wvalid |-> wlast == (beat_idx == exp_beats - 5'd1))
		else abort_run(error_line("wlast on the wrong beat"));

	// wr_rdy low from the cycle after accept to the cycle after the response
	a_rdy_flow: assert property (@(posedge clk) disable iff (!rst)
		wr_rdy == (!in_flight && awready))
		else abort_run(error_line("wr_rdy wrong for the request state"));

	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst)
		awvalid && awready |-> aw_cnt == b_cnt)
		else abort_run(error_line("address sent before the previous response"));

	initial
	begin
		int gap;
		int exp_total;

		void'($urandom(32'hd7ec));
		rst       = 1'b0;
		wr_req    = 1'b0;
		wr_addr   = '0;
		wr_type   = '0;
		wr_wstrb  = '0;
		wr_line   = '0;
		wr_word   = '0;
		uncached  = 1'b0;
		exp_addr  = '0;
		exp_size  = '0;
		exp_strb  = '0;
		exp_unc   = 1'b0;
		exp_line  = '0;
		exp_word  = '0;
		exp_total = 0;
		repeat (5) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		for (int i = 0; i < NUM_REQS; i++)
		begin
			gap = $urandom_range(0, 2);
			repeat (gap) @(negedge clk);
			while (!wr_rdy)
				@(negedge clk);
			wr_addr  = $urandom();
			wr_type  = 3'($urandom_range(0, 7));
			wr_wstrb = 4'($urandom_range(0, 15));
			wr_word  = $urandom();
			for (int w = 0; w < 16; w++)
				wr_line[32*w +: 32] = $urandom();
			// first two requests cover both kinds
			if (i < 2)
				uncached = (i == 1);
			else
				uncached = ($urandom_range(0, 2) == 0);
			exp_addr  = wr_addr;
			exp_size  = wr_type;
			exp_strb  = wr_wstrb;
			exp_unc   = uncached;
			exp_line  = wr_line;
			exp_word  = wr_word;
			exp_total = exp_total + (uncached ? 1 : 16);
			wr_req    = 1'b1;
			@(negedge clk);
			wr_req = 1'b0;
		end

		while (in_flight)
			@(negedge clk);
		if (beat_log.size() == exp_total && b_cnt == NUM_REQS && aw_cnt == NUM_REQS)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			abort_run("run ended with missing data beats or responses");
	end

endmodule

/* project.f */
axi_wr_pkg.sv
wr_req_capture.sv
wr_line_buffer.sv
axi_wr_channel.sv
axi_wr_bridge.sv
tb_axi_wr_bridge.sv

/* run.sh */
#!/bin/sh
# builds the AXI write bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_axi_wr_bridge \
	--Mdir obj_dir \
	-f project.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_axi_wr_bridge > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Everything OK$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
